// ==== filelist.f ====
hw/decoder_params_pkg.sv
hw/stage_control_pkg.sv
hw/stage_sequencer.sv
hw/deadlock_monitor.sv
hw/round_statistics.sv
hw/command_fifo.sv
hw/decoder_stage_controller.sv
testbench/report_checker.sv
testbench/tb_stage_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the stage controller testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_stage_controller \
    -f filelist.f \
    -o sim_stage_controller

./obj_dir/sim_stage_controller | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== testbench/tb_stage_controller.sv ====
`timescale 1ns/1ps

module tb_stage_controller;
    import stage_control_pkg::*;

    localparam int NUM_SCENARIOS = 6;
    localparam int WAIT_LIMIT = 2000;
    localparam int WAIT_RESULT = 0;
    localparam int WAIT_DEADLOCK = 1;
    localparam int WAIT_DRAIN = 2;

    // one decoding round per row
    typedef struct packed {
        logic [7:0] odd_rounds;
        // message_flying cycles after each accepted command
        logic [7:0] flight_cycles;
        // message_flying never drops
        logic       stuck;
        // 0 never stalls, 3 stalls on three draws in four
        logic [1:0] stall_level;
    } scenario_t;

    localparam scenario_t SCENARIOS [NUM_SCENARIOS] = '{
        '{8'd0, 8'd0, 1'b0, 2'd0},
        '{8'd2, 8'd0, 1'b0, 2'd0},
        // back-pressure row
        '{8'd3, 8'd4, 1'b0, 2'd2},
        // flight longer than the spread and sync delays
        '{8'd1, 8'd12, 1'b0, 2'd1},
        // deadlock row
        '{8'd0, 8'd0, 1'b1, 2'd0},
        '{8'd2, 8'd0, 1'b0, 2'd0}
    };

    logic               clk = 1'b0;
    logic               reset;
    logic               new_round_start;
    downstream_status_t status = '0;
    logic               cmd_ready = 1'b1;
    round_report_t      report;
    command_t           cmd_data;
    logic               cmd_valid;
    logic               check_round;
    int                 check_errors;
    int                 timeouts;

    // current row as seen by the downstream model
    int                 row_odd_rounds = 0;
    int                 row_flight_cycles = 0;
    logic               row_stuck = 1'b0;
    logic [1:0]         row_stall_level = 2'd0;

    logic               accepted_last = 1'b0;
    int                 flight_left = 0;
    logic [31:0]        rand_state = 32'h97b2_c76d;

    always #5 clk = ~clk;

    decoder_stage_controller #(
        .CODE_DISTANCE_X          (3),
        .CODE_DISTANCE_Z          (3),
        .BOUNDARY_GROW_DELAY      (3),
        .SPREAD_CLUSTER_DELAY     (9),
        .SYNC_IS_ODD_CLUSTER_DELAY(9),
        .FIFO_DEPTH               (4)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .new_round_start(new_round_start),
        .status         (status),
        .cmd_ready      (cmd_ready),
        .report         (report),
        .cmd_data       (cmd_data),
        .cmd_valid      (cmd_valid)
    );

    report_checker i_checker (
        .clk              (clk),
        .reset            (reset),
        .new_round_start  (new_round_start),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .cmd_data         (cmd_data),
        .report           (report),
        .check_round      (check_round),
        .expect_odd_rounds(row_odd_rounds),
        .expect_abort     (row_stuck),
        .error_count      (check_errors)
    );

    // lcg step, numerical recipes constants
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // transfer seen on the last rising edge
    always @(posedge clk) begin
        accepted_last <= cmd_valid && cmd_ready;
    end

    // processing array and command sink
    always @(negedge clk) begin
        if (accepted_last) begin
            flight_left = row_flight_cycles;
        end
        if (flight_left > 0) begin
            flight_left = flight_left - 1;
            status.message_flying = 1'b1;
        end else begin
            status.message_flying = row_stuck;
        end
        // odd clusters remain until K grow iterations are done
        status.odd_clusters = (int'(report.iteration_counter) < row_odd_rounds);
        if (row_stall_level == 2'd0) begin
            cmd_ready = 1'b1;
        end else begin
            rand_state = next_random(rand_state);
            cmd_ready = (rand_state[17:16] >= row_stall_level);
        end
    end

    task automatic start_round();
        @(negedge clk);
        new_round_start = 1'b1;
        @(negedge clk);
        new_round_start = 1'b0;
    endtask

    task automatic request_check();
        @(negedge clk);
        check_round = 1'b1;
        @(negedge clk);
        check_round = 1'b0;
    endtask

    // poll on falling edges until the condition holds or the limit runs out
    task automatic wait_for(input int condition, output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles = cycles + 1;
            case (condition)
                WAIT_RESULT:   ok = report.result_valid;
                WAIT_DEADLOCK: ok = report.deadlock;
                default:       ok = !cmd_valid;
            endcase
        end
        if (!ok) begin
            timeouts = timeouts + 1;
            case (condition)
                WAIT_RESULT:   $display("timeout: result_valid did not rise in %0d cycles",
                                        WAIT_LIMIT);
                WAIT_DEADLOCK: $display("timeout: deadlock did not set in %0d cycles",
                                        WAIT_LIMIT);
                default:       $display("timeout: command queue did not drain in %0d cycles",
                                        WAIT_LIMIT);
            endcase
        end
    endtask

    initial begin
        logic ok;
        reset = 1'b1;
        new_round_start = 1'b0;
        check_round = 1'b0;
        timeouts = 0;
        ok = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // a few idle cycles for the post-reset checks
        repeat (4) @(negedge clk);
        for (int row = 0; (row < NUM_SCENARIOS) && ok; row++) begin
            // row settings change away from the falling edge
            @(posedge clk);
            row_odd_rounds = int'(SCENARIOS[row].odd_rounds);
            row_flight_cycles = int'(SCENARIOS[row].flight_cycles);
            row_stuck = SCENARIOS[row].stuck;
            row_stall_level = SCENARIOS[row].stall_level;
            $display("scenario %0d: odd rounds %0d, flight %0d, stuck %0b, stall level %0d",
                     row, row_odd_rounds, row_flight_cycles, row_stuck, row_stall_level);
            start_round();
            wait_for(row_stuck ? WAIT_DEADLOCK : WAIT_RESULT, ok);
            if (ok) begin
                wait_for(WAIT_DRAIN, ok);
            end
            if (ok) begin
                request_check();
            end
        end
        repeat (3) @(negedge clk);
        $display("errors: %0d check, %0d timeout", check_errors, timeouts);
        if ((check_errors == 0) && (timeouts == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/report_checker.sv ====
`timescale 1ns/1ps

module report_checker (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             new_round_start,
    input  logic                             cmd_valid,
    input  logic                             cmd_ready,
    input  stage_control_pkg::command_t      cmd_data,
    input  stage_control_pkg::round_report_t report,
    input  logic                             check_round,
    input  int                               expect_odd_rounds,
    input  logic                             expect_abort,
    output int                               error_count
);
    import stage_control_pkg::*;
    import decoder_params_pkg::*;

    // commands the sink took this round, in order
    command_t                       accepted [$];
    int                             errors = 0;
    logic                           round_seen;
    logic                           prev_new_round;
    logic                           prev_result_valid;
    logic [CYCLE_COUNTER_WIDTH-1:0] prev_cycle_counter;
    // loading edge pending, then edges counted up to the rise
    logic                           loading_next;
    logic                           counting;
    int                             edges_after_loading;

    assign error_count = errors;

    task automatic report_error(input string message);
        errors = errors + 1;
        $display("CHECK FAILED @%0t: %s", $time, message);
    endtask

    // end of a round, queue already drained
    task automatic check_round_end();
        int       expected_words;
        int       index;
        command_t seen_cmd;
        command_t expected_cmd;
        if (expect_abort) begin
            if ((accepted.size() == 0) || (accepted[$] != cmd_abort)) begin
                report_error("last accepted command is not cmd_abort");
            end
            if (!report.deadlock) begin
                report_error("deadlock not set after a stuck round");
            end
            if (report.result_valid) begin
                report_error("result_valid set on an aborted round");
            end
        end else begin
            // start, first spread, three per odd round, then finish
            expected_words = 3 * expect_odd_rounds + 3;
            if (accepted.size() != expected_words) begin
                report_error($sformatf("%0d commands accepted, expected %0d",
                                       accepted.size(), expected_words));
            end else begin
                for (index = 0; index < expected_words; index++) begin
                    seen_cmd = accepted[index];
                    expected_cmd = (index == expected_words - 1) ? cmd_finish : cmd_advance;
                    if (seen_cmd != expected_cmd) begin
                        report_error($sformatf("command %0d is %s, expected %s", index,
                                               seen_cmd.name(), expected_cmd.name()));
                    end
                end
            end
            if (int'(report.iteration_counter) != expect_odd_rounds + 1) begin
                report_error($sformatf("iteration_counter %0d, expected %0d",
                                       report.iteration_counter, expect_odd_rounds + 1));
            end
            if (report.deadlock) begin
                report_error("deadlock set on a normal round");
            end
            if (!report.result_valid) begin
                report_error("result_valid low at the end of a normal round");
            end
        end
    endtask

    // samples are the values before this edge updates the DUT
    always @(posedge clk) begin
        if (reset) begin
            round_seen = 1'b0;
            prev_new_round = 1'b0;
            prev_result_valid = 1'b0;
            prev_cycle_counter = '0;
            loading_next = 1'b0;
            counting = 1'b0;
            edges_after_loading = 0;
            accepted.delete();
        end else begin
            // idle state after reset, before any round
            if (!round_seen && ((cmd_valid !== 1'b0) || (report !== '0))) begin
                report_error("DUT not idle after reset, cmd_valid or report not zero");
            end
            if (prev_new_round && report.deadlock) begin
                report_error("deadlock still set after new_round_start");
            end
            // counter frozen while the result is valid
            if (prev_result_valid && report.result_valid &&
                (report.cycle_counter != prev_cycle_counter)) begin
                report_error($sformatf("cycle_counter moved from %0d to %0d after result",
                                       prev_cycle_counter, report.cycle_counter));
            end
            // loading loads 1, each later edge adds one up to the rise
            if (counting && report.result_valid && !prev_result_valid) begin
                if (report.cycle_counter != CYCLE_COUNTER_WIDTH'(edges_after_loading + 1)) begin
                    report_error($sformatf("cycle_counter %0d, expected %0d",
                                           report.cycle_counter, edges_after_loading + 1));
                end
                counting = 1'b0;
            end else if (counting) begin
                edges_after_loading = edges_after_loading + 1;
            end
            if (loading_next) begin
                loading_next = 1'b0;
                counting = 1'b1;
            end
            if (new_round_start) begin
                round_seen = 1'b1;
                accepted.delete();
                loading_next = 1'b1;
                counting = 1'b0;
                edges_after_loading = 0;
            end
            if (cmd_valid && cmd_ready) begin
                accepted.push_back(cmd_data);
            end
            if (check_round) begin
                check_round_end();
            end
            prev_new_round = new_round_start;
            prev_result_valid = report.result_valid;
            prev_cycle_counter = report.cycle_counter;
        end
    end

endmodule

// ==== hw/decoder_stage_controller.sv ====
`timescale 1ns/1ps

module decoder_stage_controller #(
    parameter int CODE_DISTANCE_X = decoder_params_pkg::DEFAULT_CODE_DISTANCE,
    parameter int CODE_DISTANCE_Z = decoder_params_pkg::DEFAULT_CODE_DISTANCE,
    parameter int BOUNDARY_GROW_DELAY = decoder_params_pkg::DEFAULT_BOUNDARY_GROW_DELAY,
    parameter int SPREAD_CLUSTER_DELAY = decoder_params_pkg::DEFAULT_SPREAD_CLUSTER_DELAY,
    parameter int SYNC_IS_ODD_CLUSTER_DELAY =
        decoder_params_pkg::DEFAULT_SYNC_IS_ODD_CLUSTER_DELAY,
    parameter int FIFO_DEPTH = decoder_params_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 new_round_start,
    input  stage_control_pkg::downstream_status_t status,
    input  logic                                 cmd_ready,
    output stage_control_pkg::round_report_t     report,
    output stage_control_pkg::command_t          cmd_data,
    output logic                                 cmd_valid
);
    import stage_control_pkg::*;
    import decoder_params_pkg::*;

    // one measurement round per unit of the larger distance
    localparam int MEASUREMENT_ROUNDS =
        (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z;
    localparam int PU_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * MEASUREMENT_ROUNDS;
    // 270 at distance 3
    localparam int DEADLOCK_THRESHOLD = PU_COUNT * DEADLOCK_FACTOR;

    stage_t   stage;
    logic     stage_timeout;
    logic     deadlock;
    logic     issue_valid;
    command_t issue_cmd;
    logic     fifo_full;
    logic     fifo_empty;

    stage_sequencer #(
        .BOUNDARY_GROW_DELAY      (BOUNDARY_GROW_DELAY),
        .SPREAD_CLUSTER_DELAY     (SPREAD_CLUSTER_DELAY),
        .SYNC_IS_ODD_CLUSTER_DELAY(SYNC_IS_ODD_CLUSTER_DELAY)
    ) i_sequencer (
        .clk            (clk),
        .reset          (reset),
        .new_round_start(new_round_start),
        .status         (status),
        .stage_timeout  (stage_timeout),
        .full           (fifo_full),
        .stage          (stage),
        .issue_valid    (issue_valid),
        .issue_cmd      (issue_cmd)
    );

    deadlock_monitor #(
        .DEADLOCK_THRESHOLD(DEADLOCK_THRESHOLD)
    ) i_deadlock_monitor (
        .clk            (clk),
        .reset          (reset),
        .new_round_start(new_round_start),
        .stage          (stage),
        .stage_timeout  (stage_timeout),
        .deadlock       (deadlock)
    );

    round_statistics i_round_statistics (
        .clk     (clk),
        .reset   (reset),
        .stage   (stage),
        .deadlock(deadlock),
        .report  (report)
    );

    // outbound queue, the sink pops on ready
    command_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_command_fifo (
        .clk  (clk),
        .reset(reset),
        .wr_en(issue_valid),
        .din  (issue_cmd),
        .rd_en(cmd_ready),
        .full (fifo_full),
        .empty(fifo_empty),
        .dout (cmd_data)
    );

    assign cmd_valid = !fifo_empty;

endmodule

// ==== hw/command_fifo.sv ====
`timescale 1ns/1ps

module command_fifo #(
    parameter int DEPTH = decoder_params_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr_en,
    input  stage_control_pkg::command_t din,
    input  logic                        rd_en,
    output logic                        full,
    output logic                        empty,
    output stage_control_pkg::command_t dout
);
    import stage_control_pkg::*;

    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

    command_t               mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_write;
    logic                   do_read;

    assign full = (count == FULL_COUNT);
    assign empty = (count == '0);

    // writes past full and reads from empty are dropped
    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    // head word shows without a read request
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap at DEPTH, need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write keeps the count
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/round_statistics.sv ====
`timescale 1ns/1ps

module round_statistics (
    input  logic                             clk,
    input  logic                             reset,
    input  stage_control_pkg::stage_t        stage,
    input  logic                             deadlock,
    output stage_control_pkg::round_report_t report
);
    import stage_control_pkg::*;
    import decoder_params_pkg::*;

    stage_t                             prev_stage;
    logic                               sync_exit;
    logic                               result_valid;
    logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter;
    logic [CYCLE_COUNTER_WIDTH-1:0]     cycle_counter;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_stage <= stage_idle;
        end else begin
            prev_stage <= stage;
        end
    end

    // completed sync, either more growing or done
    // an abort to idle does not count
    assign sync_exit = (prev_stage == stage_sync_is_odd_cluster) &&
                       ((stage == stage_grow_boundary) ||
                        (stage == stage_result_calculating));

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
        end else if (stage == stage_measurement_loading) begin
            iteration_counter <= '0;
        end else if (sync_exit) begin
            iteration_counter <= iteration_counter + 1'b1;
        end
    end

    // result stage is one cycle, so it always steps to idle here
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (stage == stage_measurement_loading) begin
            result_valid <= 1'b0;
        end else if (stage == stage_result_calculating) begin
            result_valid <= 1'b1;
        end
    end

    // round length, frozen once the result is valid
    // idle without a result means no round running
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_counter <= '0;
        end else if (stage == stage_measurement_loading) begin
            cycle_counter <= CYCLE_COUNTER_WIDTH'(1);
        end else if (!result_valid && (stage != stage_idle)) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    always_comb begin
        report.result_valid = result_valid;
        report.deadlock = deadlock;
        report.iteration_counter = iteration_counter;
        report.cycle_counter = cycle_counter;
    end

endmodule

// ==== hw/deadlock_monitor.sv ====
`timescale 1ns/1ps

module deadlock_monitor #(
    parameter int DEADLOCK_THRESHOLD = 270
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      new_round_start,
    input  stage_control_pkg::stage_t stage,
    output logic                      stage_timeout,
    output logic                      deadlock
);
    import stage_control_pkg::*;
    import decoder_params_pkg::*;

    logic [CYCLE_COUNTER_WIDTH-1:0] cycles_in_stage;

    // cycles spent waiting on the array
    // spread and sync accumulate, grow restarts the count
    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_in_stage <= '0;
        end else begin
            case (stage)
                stage_idle, stage_measurement_loading, stage_grow_boundary: begin
                    cycles_in_stage <= '0;
                end
                stage_spread_cluster, stage_sync_is_odd_cluster: begin
                    cycles_in_stage <= cycles_in_stage + 1'b1;
                end
                default: begin
                    cycles_in_stage <= cycles_in_stage;
                end
            endcase
        end
    end

    // level while over the limit
    assign stage_timeout = (cycles_in_stage > DEADLOCK_THRESHOLD);

    // sticky for the rest of the round
    always_ff @(posedge clk) begin
        if (reset) begin
            deadlock <= 1'b0;
        end else if (new_round_start) begin
            deadlock <= 1'b0;
        end else if (stage_timeout) begin
            deadlock <= 1'b1;
        end
    end

endmodule

// ==== hw/stage_sequencer.sv ====
`timescale 1ns/1ps

module stage_sequencer #(
    parameter int BOUNDARY_GROW_DELAY = decoder_params_pkg::DEFAULT_BOUNDARY_GROW_DELAY,
    parameter int SPREAD_CLUSTER_DELAY = decoder_params_pkg::DEFAULT_SPREAD_CLUSTER_DELAY,
    parameter int SYNC_IS_ODD_CLUSTER_DELAY =
        decoder_params_pkg::DEFAULT_SYNC_IS_ODD_CLUSTER_DELAY
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 new_round_start,
    input  stage_control_pkg::downstream_status_t status,
    input  logic                                 stage_timeout,
    input  logic                                 full,
    output stage_control_pkg::stage_t            stage,
    output logic                                 issue_valid,
    output stage_control_pkg::command_t          issue_cmd
);
    import stage_control_pkg::*;

    // counter sized for the longest stage
    localparam int SPREAD_SYNC_MAX = (SPREAD_CLUSTER_DELAY > SYNC_IS_ODD_CLUSTER_DELAY) ?
        SPREAD_CLUSTER_DELAY : SYNC_IS_ODD_CLUSTER_DELAY;
    localparam int MAXIMUM_DELAY = (BOUNDARY_GROW_DELAY > SPREAD_SYNC_MAX) ?
        BOUNDARY_GROW_DELAY : SPREAD_SYNC_MAX;
    localparam int COUNTER_WIDTH = $clog2(MAXIMUM_DELAY + 1);

    localparam logic [COUNTER_WIDTH-1:0] GROW_LAST = COUNTER_WIDTH'(BOUNDARY_GROW_DELAY);
    localparam logic [COUNTER_WIDTH-1:0] SPREAD_LAST = COUNTER_WIDTH'(SPREAD_CLUSTER_DELAY);
    localparam logic [COUNTER_WIDTH-1:0] SYNC_LAST = COUNTER_WIDTH'(SYNC_IS_ODD_CLUSTER_DELAY);

    logic [COUNTER_WIDTH-1:0] delay_counter;
    logic [COUNTER_WIDTH-1:0] stage_delay;
    logic                     delay_done;
    stage_t                   stage_next;

    // minimum dwell of the current stage
    // untimed stages use zero so they are always done
    always_comb begin
        case (stage)
            stage_spread_cluster:      stage_delay = SPREAD_LAST;
            stage_sync_is_odd_cluster: stage_delay = SYNC_LAST;
            stage_grow_boundary:       stage_delay = GROW_LAST;
            default:                   stage_delay = '0;
        endcase
    end

    assign delay_done = (delay_counter >= stage_delay);

    // next stage and the command written on the hand-off
    // every hand-off needs queue space, else the stage holds
    always_comb begin
        stage_next = stage;
        issue_valid = 1'b0;
        issue_cmd = cmd_none;
        case (stage)
            stage_idle: begin
                if (new_round_start && !full) begin
                    stage_next = stage_measurement_loading;
                    issue_valid = 1'b1;
                    issue_cmd = cmd_advance;
                end
            end
            stage_measurement_loading: begin
                // single cycle, syndrome comes from the external buffer
                stage_next = stage_spread_cluster;
            end
            stage_spread_cluster: begin
                if (delay_done && !full) begin
                    if (!status.message_flying) begin
                        stage_next = stage_sync_is_odd_cluster;
                        issue_valid = 1'b1;
                        issue_cmd = cmd_advance;
                    end else if (stage_timeout) begin
                        // array never drained, give up on the round
                        stage_next = stage_idle;
                        issue_valid = 1'b1;
                        issue_cmd = cmd_abort;
                    end
                end
            end
            stage_grow_boundary: begin
                // grow leaves on its delay alone
                if (delay_done && !full) begin
                    stage_next = stage_spread_cluster;
                    issue_valid = 1'b1;
                    issue_cmd = cmd_advance;
                end
            end
            stage_sync_is_odd_cluster: begin
                if (delay_done && !full) begin
                    if (!status.message_flying) begin
                        if (status.odd_clusters) begin
                            // another grow iteration
                            stage_next = stage_grow_boundary;
                            issue_valid = 1'b1;
                            issue_cmd = cmd_advance;
                        end else begin
                            stage_next = stage_result_calculating;
                            issue_valid = 1'b1;
                            issue_cmd = cmd_finish;
                        end
                    end else if (stage_timeout) begin
                        stage_next = stage_idle;
                        issue_valid = 1'b1;
                        issue_cmd = cmd_abort;
                    end
                end
            end
            stage_result_calculating: begin
                stage_next = stage_idle;
            end
            default: begin
                stage_next = stage_idle;
            end
        endcase
    end

    // stage register and dwell counter
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_idle;
            delay_counter <= '0;
        end else begin
            stage <= stage_next;
            if (stage_next != stage) begin
                // restart dwell on every hand-off
                delay_counter <= '0;
            end else if (!delay_done) begin
                delay_counter <= delay_counter + 1'b1;
            end
        end
    end

endmodule

// ==== hw/stage_control_pkg.sv ====
package stage_control_pkg;

    // decoding round stages
    typedef enum logic [2:0] {
        stage_idle                = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_spread_cluster      = 3'd2,
        stage_grow_boundary       = 3'd3,
        stage_sync_is_odd_cluster = 3'd4,
        stage_result_calculating  = 3'd5
    } stage_t;

    // command words to the downstream chain
    typedef enum logic [2:0] {
        // no command, default on the issue port
        cmd_none    = 3'd0,
        // step to the next stage
        cmd_advance = 3'd1,
        // all clusters resolved
        cmd_finish  = 3'd2,
        // deadlock abort from spread or sync
        cmd_abort   = 3'd3
    } command_t;

    // status reported back by the processing array
    typedef struct packed {
        // some unit still has a message in transit
        logic message_flying;
        // at least one cluster has odd cardinality
        logic odd_clusters;
    } downstream_status_t;

    // per-round report, 42 bits
    typedef struct packed {
        logic                                                  result_valid;
        logic                                                  deadlock;
        logic [decoder_params_pkg::ITERATION_COUNTER_WIDTH-1:0] iteration_counter;
        logic [decoder_params_pkg::CYCLE_COUNTER_WIDTH-1:0]     cycle_counter;
    } round_report_t;

endpackage

// ==== hw/decoder_params_pkg.sv ====
package decoder_params_pkg;

    // counter widths
    // up to 255 grow iterations per round
    localparam int ITERATION_COUNTER_WIDTH = 8;
    localparam int CYCLE_COUNTER_WIDTH = 32;

    // default code geometry
    localparam int DEFAULT_CODE_DISTANCE = 3;

    // minimum cycles per timed stage
    // grow only needs the boundary update to settle
    localparam int DEFAULT_BOUNDARY_GROW_DELAY = 3;
    // spread and sync cover the message path through the array
    localparam int DEFAULT_SPREAD_CLUSTER_DELAY = 9;
    localparam int DEFAULT_SYNC_IS_ODD_CLUSTER_DELAY = 9;

    // outbound command queue
    localparam int DEFAULT_FIFO_DEPTH = 16;

    // deadlock threshold is this many cycles per processing unit
    localparam int DEADLOCK_FACTOR = 10;

endpackage
